//--- source/cosTable.mem
7E00C000
7A00C000
7600C000
7200C000
6E00C000
6A00C000
6600C000
6200C000
5E00C000
5A00C000
5600C000
5200C000
4E00C000
4A00C000
4600C000
4200C000
3E00C000
3A00C000
3600C000
3200C000
2E00C000
2A00C000
2600C000
2200C000
1E00C000
1A00C000
1600C000
1200C000
0E00C000
0A00C000
0600C000
0200C000
FE00C000
FA00C000
F600C000
F200C000
EE00C000
EA00C000
E600C000
E200C000
DE00C000
DA00C000
D600C000
D200C000
CE00C000
CA00C000
C600C000
C200C000
BE00C000
BA00C000
B600C000
B200C000
AE00C000
AA00C000
A600C000
A200C000
9E00C000
9A00C000
9600C000
9200C000
8E00C000
8A00C000
8600C000
8200C000

//--- tb/lsfLspGolden.txt
# Kind L: ten LSF input words of one frame, hex
# Kind P: ten expected LSP words of the same frame, hex, sign-extended
L 00000500 00000C00 00001400 00001F00 00002800 00003400 00003F00 00004A00 00005500 00006000
P 00007148 00005F74 00004B14 00002F10 00001824 FFFFF998 FFFFDD94 FFFFC190 FFFFA58C FFFF898C
L 00000300 00000900 00001100 00001A00 00002500 00002F00 00003A00 00004500 00005000 00005C00
P 00007660 00006718 000052B8 00003BCC 00001FC8 00000654 FFFFEA50 FFFFCE4C FFFFB248 FFFF93BC
L 00000700 00000E00 00001600 00002100 00002C00 00003700 00004200 00004D00 00005800 00006300
P 00006C30 00005A5C 000045FC 000029F8 00000DF8 FFFFF1F4 FFFFD5F0 FFFFB9EC FFFF9DEC FFFF81E8
L 00000200 00000A00 00001300 00001C00 00002700 00003200 00003D00 00004800 00005300 00005E00
P 000078EC 0000648C 00004DA0 000036B4 00001AB0 FFFFFEB0 FFFFE2AC FFFFC6A8 FFFFAAA4 FFFF8EA4
L 00000600 00000D00 00001800 00002300 00002D00 00003800 00004300 00004E00 00005900 00006400
P 00006EBC 00005CE8 000040E4 000024E0 00000B6C FFFFEF68 FFFFD364 FFFFB760 FFFF9B60 FFFF8000
L 00000400 00000B00 00001500 00001E00 00002900 00003500 00004000 00004B00 00005600 00006100
P 000073D4 00006200 00004888 0000319C 00001598 FFFFF70C FFFFDB08 FFFFBF04 FFFFA304 FFFF8700
L 00000800 00001000 00001900 00002400 00002E00 00003900 00004400 00004F00 00005A00 00006200
P 000069A4 00005544 00003E58 00002254 000008E0 FFFFECDC FFFFD0D8 FFFFB4D4 FFFF98D4 FFFF8474
L 00000100 00000F00 00001700 00002200 00002B00 00003600 00004100 00004C00 00005700 00005F00
P 00007B78 000057D0 00004370 0000276C 00001084 FFFFF480 FFFFD87C FFFFBC78 FFFFA078 FFFF8C18
L 00003C00 00004600 00005000 00005A00 00006500 00006900 00006E00 00007300 00007800 00007F00
P FFFFE538 FFFFCBC0 FFFFB248 FFFF98D4 FFFF80D0 FFFF8000 FFFF81E4 FFFF8128 FFFF806C FFFF8000
L 00003100 00003300 00003E00 00004900 00005100 00005B00 00006600 00006C00 00007600 00007D00
P 0000013C FFFFFC24 FFFFE020 FFFFC41C FFFFAFBC FFFF9648 FFFF8000 FFFF8000 FFFF8184 FFFF8000

//--- vlog.f
source/lspPkg.sv
source/basicOpIf.sv
source/memPortIf.sv
source/basicOpUnit.sv
source/cosTableRom.sv
source/scratchMemory.sv
source/lsfLspFsm.sv
source/lsfLspPipe.sv
tb/lsfLspPipeTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the LSF to LSP testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f \
  --top-module lsfLspPipeTb \
  -o simv

./obj_dir/simv | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- tb/lsfLspPipeTb.sv
`timescale 1ns/100ps

module lsfLspPipeTb;

  localparam int frames = 10;
  localparam int order = 10;

  logic clk = 1'b0;
  logic rst;
  logic start;
  logic [10:0] lsfAddr;
  logic [10:0] lspAddr;
  logic memMuxSel;
  logic [10:0] testReadAddr;
  logic [10:0] testWriteAddr;
  logic [31:0] testWriteData;
  logic testWriteEn;
  logic [31:0] testReadData;
  logic done;

  logic [31:0] lsfIn [frames][order];
  logic [31:0] lspExp [frames][order];
  logic [31:0] lcgState = 32'h6bd4;
  int mismatches = 0;
  int otherErrors = 0;
  int doneCount = 0;

  lsfLspPipe #(.depth(2048), .dataW(32)) u_dut (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .lsfAddr       (lsfAddr),
    .lspAddr       (lspAddr),
    .memMuxSel     (memMuxSel),
    .testReadAddr  (testReadAddr),
    .testWriteAddr (testWriteAddr),
    .testWriteData (testWriteData),
    .testWriteEn   (testWriteEn),
    .testReadData  (testReadData),
    .done          (done)
  );

  always #50 clk = ~clk;

  // done is a one-cycle pulse, so counting at the falling edge sees each one
  always @(negedge clk)
  begin
    if (!rst && done)
      doneCount <= doneCount + 1;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got == exp)
    else
    begin
      mismatches++;
      $display("MISMATCH at %0t: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic writeWord(input logic [10:0] addr, input logic [31:0] data);
    @(posedge clk);
    testWriteAddr <= addr;
    testWriteData <= data;
    testWriteEn <= 1'b1;
    @(posedge clk);
    testWriteEn <= 1'b0;
  endtask

  task automatic readWord(input logic [10:0] addr, output logic [31:0] data);
    @(posedge clk);
    testReadAddr <= addr;
    @(posedge clk);
    @(negedge clk);
    data = testReadData;
  endtask

  task automatic loadGolden();
    int fd;
    int code;
    int lRow;
    int pRow;
    logic [63:0] kind;
    logic [31:0] value;
    string rest;
    lRow = 0;
    pRow = 0;
    fd = $fopen("tb/lsfLspGolden.txt", "r");
    if (fd == 0)
    begin
      otherErrors++;
      $display("Could not open the golden file tb/lsfLspGolden.txt");
      return;
    end
    while (!$feof(fd))
    begin
      code = $fscanf(fd, "%s", kind);
      if (code != 1)
        break;
      if (kind == "#")
        code = $fgets(rest, fd);
      else
      begin
        for (int i = 0; i < order; i++)
        begin
          code = $fscanf(fd, "%h", value);
          if (kind == "L" && lRow < frames)
            lsfIn[lRow][i] = value;
          else if (kind == "P" && pRow < frames)
            lspExp[pRow][i] = value;
        end
        if (kind == "L")
          lRow++;
        else
          pRow++;
      end
    end
    $fclose(fd);
    if (lRow != frames || pRow != frames)
    begin
      otherErrors++;
      $display("Golden file holds %0d input and %0d output rows, not %0d each",
               lRow, pRow, frames);
    end
  endtask

  task automatic waitForDone(output bit seen);
    int cycles;
    seen = 1'b0;
    for (cycles = 0; cycles < 200 && !seen; cycles++)
    begin
      @(negedge clk);
      if (done)
        seen = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One frame: load, convert, read back
  ////////////////////////////////////////////////////////////////////////////

  task automatic runFrame(input int f);
    logic [10:0] lsfBase;
    logic [10:0] lspBase;
    logic [31:0] word;
    logic [31:0] sentinelLo;
    logic [31:0] sentinelHi;
    bit seen;
    // Input region below 1024, output region above, so they never overlap
    lsfBase = 11'(16 + (int'(nextRand() >> 8) % 900));
    lspBase = 11'(1040 + (int'(nextRand() >> 8) % 900));
    sentinelLo = {16'hA5A5, 5'd0, lspBase - 11'd1};
    sentinelHi = {16'h5A5A, 5'd0, lspBase + 11'd10};
    for (int i = 0; i < order; i++)
      writeWord(lsfBase + 11'(i), lsfIn[f][i]);
    writeWord(lspBase - 11'd1, sentinelLo);
    writeWord(lspBase + 11'd10, sentinelHi);

    @(posedge clk);
    memMuxSel <= 1'b1;
    lsfAddr <= lsfBase;
    lspAddr <= lspBase;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    waitForDone(seen);
    assert (seen)
    else
    begin
      otherErrors++;
      $display("Timed out waiting for done in frame %0d", f);
    end
    @(posedge clk);
    memMuxSel <= 1'b0;
    repeat (2) @(posedge clk);
    assert (doneCount == f + 1)
    else
    begin
      otherErrors++;
      $display("done pulsed %0d times after %0d starts", doneCount, f + 1);
    end

    for (int i = 0; i < order; i++)
    begin
      readWord(lspBase + 11'(i), word);
      checkWord(word, lspExp[f][i], $sformatf("frame %0d lsp[%0d]", f, i));
    end
    readWord(lspBase - 11'd1, word);
    checkWord(word, sentinelLo, $sformatf("frame %0d low sentinel", f));
    readWord(lspBase + 11'd10, word);
    checkWord(word, sentinelHi, $sformatf("frame %0d high sentinel", f));
    // Engine must leave its inputs alone
    for (int i = 0; i < order; i++)
    begin
      readWord(lsfBase + 11'(i), word);
      checkWord(word, lsfIn[f][i], $sformatf("frame %0d lsf[%0d]", f, i));
    end
  endtask

  initial
  begin
    rst = 1'b1;
    start = 1'b0;
    lsfAddr = '0;
    lspAddr = '0;
    memMuxSel = 1'b0;
    testReadAddr = '0;
    testWriteAddr = '0;
    testWriteData = '0;
    testWriteEn = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    loadGolden();
    repeat (4) @(posedge clk);
    @(negedge clk);
    assert (doneCount == 0 && done == 1'b0)
    else
    begin
      otherErrors++;
      $display("done went high before the first start");
    end
    if (otherErrors == 0)
    begin
      for (int f = 0; f < frames; f++)
        runFrame(f);
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
    if (mismatches == 0 && otherErrors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- source/lsfLspPipe.sv
`timescale 1ns/100ps

module lsfLspPipe #(
  parameter int depth = 2048,
  parameter int dataW = 32
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic [lspPkg::addrW-1:0] lsfAddr,
  input  logic [lspPkg::addrW-1:0] lspAddr,
  input  logic memMuxSel,
  input  logic [lspPkg::addrW-1:0] testReadAddr,
  input  logic [lspPkg::addrW-1:0] testWriteAddr,
  input  logic [dataW-1:0] testWriteData,
  input  logic testWriteEn,
  output logic [dataW-1:0] testReadData,
  output logic done
);

  basicOpIf opBus ();
  memPortIf #(.dataW(dataW)) enginePort ();
  memPortIf #(.dataW(dataW)) hostPort ();

  logic [lspPkg::romAddrW-1:0] romAddr;
  logic [lspPkg::wordW-1:0] romData;

  ////////////////////////////////////////////////////////////////////////////
  // Engine
  ////////////////////////////////////////////////////////////////////////////

  lsfLspFsm u_fsm (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .lsfAddr (lsfAddr),
    .lspAddr (lspAddr),
    .done    (done),
    .ops     (opBus.requester),
    .mem     (enginePort.master),
    .romAddr (romAddr),
    .romData (romData)
  );

  basicOpUnit u_basicOp (
    .ops (opBus.operator)
  );

  cosTableRom u_cosTable (
    .clk  (clk),
    .addr (romAddr),
    .data (romData)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Scratch memory and host access
  ////////////////////////////////////////////////////////////////////////////

  assign hostPort.readAddr = testReadAddr;
  assign hostPort.writeAddr = testWriteAddr;
  assign hostPort.writeData = testWriteData;
  assign hostPort.writeEn = testWriteEn;
  assign testReadData = hostPort.readData;

  scratchMemory #(
    .depth (depth),
    .dataW (dataW)
  ) u_scratch (
    .clk       (clk),
    .memMuxSel (memMuxSel),
    .engine    (enginePort.slave),
    .host      (hostPort.slave)
  );

endmodule

//--- source/lsfLspFsm.sv
`timescale 1ns/100ps

module lsfLspFsm (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic [lspPkg::addrW-1:0] lsfAddr,
  input  logic [lspPkg::addrW-1:0] lspAddr,
  output logic done,
  basicOpIf.requester ops,
  memPortIf.master mem,
  output logic [lspPkg::romAddrW-1:0] romAddr,
  input  logic [lspPkg::wordW-1:0] romData
);

  localparam int countW = 4;
  localparam logic [lspPkg::wordW-1:0] indexShift = 32'd8;

  lspPkg::fsmStateE state;
  lspPkg::fsmStateE nextState;

  logic [countW-1:0] count;
  logic [countW-1:0] readCount;
  logic lastCoef;
  logic [lspPkg::addrW-1:0] lsfBase;
  logic [lspPkg::addrW-1:0] lspBase;

  // Per-coefficient working registers
  logic [lspPkg::sampleW-1:0] freq;
  logic [lspPkg::romAddrW-1:0] index;
  logic [lspPkg::sampleW-1:0] offset;
  logic [lspPkg::wordW-1:0] product;
  logic [lspPkg::sampleW-1:0] base;
  logic [lspPkg::sampleW-1:0] interp;
  logic [lspPkg::sampleW-1:0] slope;

  assign lastCoef = (count == countW'(lspPkg::lpcOrder - 1));
  assign slope = romData[lspPkg::sampleW-1:0];
  assign romAddr = index;
  assign done = (state == lspPkg::sDone);

  ////////////////////////////////////////////////////////////////////////////
  // State and coefficient counter
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    nextState = state;
    case (state)
      lspPkg::sIdle:    if (start) nextState = lspPkg::sReadLsf;
      lspPkg::sReadLsf: nextState = lspPkg::sScale;
      lspPkg::sScale:   nextState = lspPkg::sIndex;
      lspPkg::sIndex:   nextState = lspPkg::sLookup;
      lspPkg::sLookup:  nextState = lspPkg::sInterp;
      lspPkg::sInterp:  nextState = lspPkg::sWrite;
      lspPkg::sWrite:   nextState = lastCoef ? lspPkg::sDone : lspPkg::sReadLsf;
      default:          nextState = lspPkg::sIdle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= lspPkg::sIdle;
      count <= '0;
    end
    else
    begin
      state <= nextState;
      if (state == lspPkg::sIdle)
        count <= '0;
      else if (state == lspPkg::sWrite)
        count <= count + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operator requests, one per state
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    ops.op = lspPkg::opAdd;
    ops.a = '0;
    ops.b = '0;
    case (state)
      lspPkg::sReadLsf:
      begin
        ops.op = lspPkg::opMult;
        ops.a = lspPkg::signExt(mem.readData[lspPkg::sampleW-1:0]);
        ops.b = lspPkg::lsfScale;
      end
      lspPkg::sScale:
      begin
        ops.op = lspPkg::opShr;
        ops.a = lspPkg::signExt(freq);
        ops.b = indexShift;
      end
      lspPkg::sIndex:
      begin
        ops.op = lspPkg::opMaskLow;
        ops.a = lspPkg::signExt(freq);
      end
      lspPkg::sLookup:
      begin
        ops.op = lspPkg::opLMult;
        ops.a = lspPkg::signExt(slope);
        ops.b = lspPkg::signExt(offset);
      end
      lspPkg::sInterp:
      begin
        ops.op = lspPkg::opLShr;
        ops.a = product;
        ops.b = lspPkg::interpShift;
      end
      lspPkg::sWrite:
      begin
        ops.a = lspPkg::signExt(base);
        ops.b = lspPkg::signExt(interp);
      end
      default:
      begin
        ops.op = lspPkg::opAdd;
      end
    endcase
  end

  // Working registers capture the result of the current state's request
  always_ff @(posedge clk)
  begin
    case (state)
      lspPkg::sIdle:
      begin
        if (start)
        begin
          lsfBase <= lsfAddr;
          lspBase <= lspAddr;
        end
      end
      lspPkg::sReadLsf: freq <= ops.result[lspPkg::sampleW-1:0];
      lspPkg::sScale:
      begin
        if ($signed(ops.result[lspPkg::sampleW-1:0]) > lspPkg::indexMax)
          index <= lspPkg::indexMax[lspPkg::romAddrW-1:0];
        else
          index <= ops.result[lspPkg::romAddrW-1:0];
      end
      lspPkg::sIndex: offset <= ops.result[lspPkg::sampleW-1:0];
      lspPkg::sLookup:
      begin
        product <= ops.result;
        base <= romData[lspPkg::wordW-1:lspPkg::sampleW];
      end
      lspPkg::sInterp: interp <= ops.result[lspPkg::sampleW-1:0];
      default:
      begin
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Scratch memory port
  ////////////////////////////////////////////////////////////////////////////

  // LSF word is requested a cycle ahead so it sits on readData in sReadLsf
  assign readCount = (state == lspPkg::sWrite) ? count + 1'b1 : count;
  assign mem.readAddr = (state == lspPkg::sIdle) ? lsfAddr :
                        lsfBase + {{(lspPkg::addrW-countW){1'b0}}, readCount};

  assign mem.writeAddr = lspBase + {{(lspPkg::addrW-countW){1'b0}}, count};
  assign mem.writeData = ops.result;
  assign mem.writeEn = (state == lspPkg::sWrite);

endmodule

//--- source/scratchMemory.sv
`timescale 1ns/100ps

module scratchMemory #(
  parameter int depth = 2048,
  parameter int dataW = 32
) (
  input  logic clk,
  input  logic memMuxSel,
  memPortIf.slave engine,
  memPortIf.slave host
);

  logic [dataW-1:0] memArray [depth];

  logic [lspPkg::addrW-1:0] readAddrSel;
  logic [lspPkg::addrW-1:0] writeAddrSel;
  logic [dataW-1:0] writeDataSel;
  logic writeEnSel;
  logic [dataW-1:0] readDataQ;

  // Host owns both ports at 0, engine at 1
  always_comb
  begin
    if (memMuxSel)
    begin
      readAddrSel = engine.readAddr;
      writeAddrSel = engine.writeAddr;
      writeDataSel = engine.writeData;
      writeEnSel = engine.writeEn;
    end
    else
    begin
      readAddrSel = host.readAddr;
      writeAddrSel = host.writeAddr;
      writeDataSel = host.writeData;
      writeEnSel = host.writeEn;
    end
  end

  always_ff @(posedge clk)
  begin
    if (writeEnSel)
      memArray[writeAddrSel] <= writeDataSel;
    readDataQ <= memArray[readAddrSel];
  end

  assign engine.readData = readDataQ;
  assign host.readData = readDataQ;

endmodule

//--- source/cosTableRom.sv
`timescale 1ns/100ps

module cosTableRom (
  input  logic clk,
  input  logic [lspPkg::romAddrW-1:0] addr,
  output logic [lspPkg::wordW-1:0] data
);

  localparam int entries = 2 ** lspPkg::romAddrW;

  // Base cosine in the upper half, slope in the lower half
  logic [lspPkg::wordW-1:0] romArray [entries];

  initial
  begin
    $readmemh("source/cosTable.mem", romArray);
  end

  // Registered output, data follows addr by one clock
  always_ff @(posedge clk)
  begin
    data <= romArray[addr];
  end

endmodule

//--- source/basicOpUnit.sv
`timescale 1ns/100ps

module basicOpUnit (
  basicOpIf.operator ops
);

  localparam int sW = lspPkg::sampleW;
  localparam int wW = lspPkg::wordW;
  localparam logic signed [sW-1:0] maxWord16 = {1'b0, {(sW-1){1'b1}}};
  localparam logic signed [sW-1:0] minWord16 = {1'b1, {(sW-1){1'b0}}};
  localparam logic signed [wW-1:0] maxWord32 = {1'b0, {(wW-1){1'b1}}};
  localparam logic signed [2*sW-1:0] squareOfMin = {2'b01, {(2*sW-2){1'b0}}};
  localparam logic [wW-1:0] lowByteMask = {{(wW-8){1'b0}}, 8'hff};

  logic signed [sW-1:0] a16;
  logic signed [sW-1:0] b16;
  logic signed [wW-1:0] a32;
  logic signed [2*sW-1:0] prod;
  logic prodOverflow;
  logic signed [sW:0] sum;

  logic signed [sW-1:0] multSat;
  logic signed [sW-1:0] shrOut;
  logic signed [sW-1:0] addSat;
  logic signed [wW-1:0] lMultSat;
  logic signed [wW-1:0] lShrOut;

  assign a16 = ops.a[sW-1:0];
  assign b16 = ops.b[sW-1:0];
  assign a32 = ops.a;

  // Only -1.0 times -1.0 leaves the Q15 range
  assign prod = a16 * b16;
  assign prodOverflow = (prod == squareOfMin);

  assign multSat = prodOverflow ? maxWord16 : prod[2*sW-2:sW-1];
  assign lMultSat = prodOverflow ? maxWord32 : {prod[2*sW-2:0], 1'b0};

  // Negative shift counts leave the value unchanged
  assign shrOut = (b16 < 0) ? a16 : a16 >>> b16;
  assign lShrOut = (b16 < 0) ? a32 : a32 >>> b16;

  assign sum = {a16[sW-1], a16} + {b16[sW-1], b16};
  always_comb
  begin
    if (sum[sW] != sum[sW-1])
      addSat = sum[sW] ? minWord16 : maxWord16;
    else
      addSat = sum[sW-1:0];
  end

  always_comb
  begin
    case (ops.op)
      lspPkg::opMult:    ops.result = lspPkg::signExt(multSat);
      lspPkg::opShr:     ops.result = lspPkg::signExt(shrOut);
      lspPkg::opLMult:   ops.result = lMultSat;
      lspPkg::opLShr:    ops.result = lShrOut;
      lspPkg::opAdd:     ops.result = lspPkg::signExt(addSat);
      lspPkg::opMaskLow: ops.result = ops.a & lowByteMask;
      default:           ops.result = '0;
    endcase
  end

endmodule

//--- source/memPortIf.sv
`timescale 1ns/100ps

interface memPortIf #(
  parameter int dataW = lspPkg::wordW
);

  logic [lspPkg::addrW-1:0] readAddr;
  logic [lspPkg::addrW-1:0] writeAddr;
  logic [dataW-1:0] writeData;
  logic writeEn;
  // Valid one clock after readAddr
  logic [dataW-1:0] readData;

  modport master (output readAddr, output writeAddr, output writeData, output writeEn,
                  input readData);
  modport slave (input readAddr, input writeAddr, input writeData, input writeEn,
                 output readData);

endinterface

//--- source/basicOpIf.sv
`timescale 1ns/100ps

// One operator request per cycle, result comes back combinationally
interface basicOpIf;

  lspPkg::basicOpE op;
  logic [lspPkg::wordW-1:0] a;
  logic [lspPkg::wordW-1:0] b;
  logic [lspPkg::wordW-1:0] result;

  modport requester (
    output op,
    output a,
    output b,
    input  result
  );

  modport operator (
    input  op,
    input  a,
    input  b,
    output result
  );

endinterface

//--- source/lspPkg.sv
package lspPkg;

  // Datapath widths
  localparam int wordW = 32;
  localparam int sampleW = 16;
  localparam int addrW = 11;
  localparam int romAddrW = 6;

  // Conversion constants
  localparam int lpcOrder = 10;
  localparam logic [wordW-1:0] lsfScale = 32'd20861;
  localparam logic [wordW-1:0] interpShift = 32'd13;
  localparam logic signed [sampleW-1:0] indexMax = 16'sd63;

  typedef enum logic [2:0] {
    opMult,
    opShr,
    opLMult,
    opLShr,
    opAdd,
    opMaskLow
  } basicOpE;

  typedef enum logic [2:0] {
    sIdle,
    sReadLsf,
    sScale,
    sIndex,
    sLookup,
    sInterp,
    sWrite,
    sDone
  } fsmStateE;

  // Q15 value widened to a full word
  function automatic logic [wordW-1:0] signExt(logic [sampleW-1:0] value);
    return {{(wordW-sampleW){value[sampleW-1]}}, value};
  endfunction

endpackage
